//--- ddr_test_pkg.sv
// Shared types and status map for the DDR test harness; the status map must fit in 256 words
package ddr_test_pkg;

  // Status window geometry
  localparam int word_bits        = 16;
  localparam int status_addr_bits = 8;

  // Burst shape as seen on the controller FIFOs
  localparam int beats_per_burst = 2; // 128-bit beats
  localparam int words_per_burst = 4; // 64-bit pattern words

  typedef enum logic [2:0] {
    st_idle,
    st_wr_beat0,
    st_wr_beat1,
    st_wr_backoff,
    st_rd_turn,
    st_rd_issue,
    st_rd_backoff,
    st_wait_data
  } test_state_e;

  // Status word 0 layout
  localparam int flag_done_bit  = 0;
  localparam int flag_fault_bit = 1;
  localparam int flag_afull_bit = 2;
  localparam int fault_cnt_lsb  = 4;

  // Word map
  localparam int afull_addr_word = 1; // Two words, low half first
  localparam int fault_base_word = 3; // Fault entries follow

endpackage

//--- test_ctrl.sv
// Test sequencer; almost full is honoured only at burst boundaries, so the FIFO margin must cover one write
module test_ctrl import ddr_test_pkg::*; (
  input  logic        clk,
  input  logic        module_rst,
  input  logic        start_i,
  input  logic        soft_rst_i,
  input  logic        phy_rdy_i,
  input  logic        af_afull_i,
  input  logic        df_afull_i,
  input  logic        last_burst_i,
  input  logic        check_done_i,
  output logic        harness_rst_o,
  output test_state_e state_o,
  output logic        rd_wr_n_o,
  output logic        af_we_o,
  output logic        df_we_o,
  output logic        done_o
);

  test_state_e state_q;
  logic        soft_q;
  logic        start_q;
  logic        soft_rise;
  logic        start_rise;
  logic        afull;

  // Soft reset edge, primed high so a held level does not retrigger
  always_ff @(posedge clk) begin
    if (module_rst) begin
      soft_q <= 1'b1;
    end else begin
      soft_q <= soft_rst_i;
    end
  end

  assign soft_rise     = soft_rst_i & ~soft_q;
  assign harness_rst_o = module_rst | soft_rise | ~phy_rdy_i;

  always_ff @(posedge clk) begin
    if (harness_rst_o) begin
      start_q <= 1'b1; // Start must go low again after any reset
    end else begin
      start_q <= start_i;
    end
  end

  assign start_rise = start_i & ~start_q;
  assign afull      = af_afull_i | df_afull_i;

  always_ff @(posedge clk) begin
    if (harness_rst_o) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:       if (start_rise) state_q <= st_wr_beat0;
        st_wr_beat0:   state_q <= st_wr_beat1;
        st_wr_beat1: begin
          if (last_burst_i) state_q <= st_rd_turn;
          else if (afull)   state_q <= st_wr_backoff;
          else              state_q <= st_wr_beat0;
        end
        st_wr_backoff: if (!afull) state_q <= st_wr_beat0;
        st_rd_turn:    state_q <= st_rd_issue; // Burst address reloads here
        st_rd_issue: begin
          if (last_burst_i) state_q <= st_wait_data;
          else if (afull)   state_q <= st_rd_backoff;
        end
        st_rd_backoff: if (!afull) state_q <= st_rd_issue;
        st_wait_data:  if (check_done_i) state_q <= st_idle;
        default:       state_q <= st_idle;
      endcase
    end
  end

  assign state_o   = state_q;
  assign rd_wr_n_o = (state_q != st_wr_beat0);
  assign af_we_o   = (state_q == st_wr_beat0) || (state_q == st_rd_issue);
  assign df_we_o   = (state_q == st_wr_beat0) || (state_q == st_wr_beat1);

  always_ff @(posedge clk) begin
    if (harness_rst_o) begin
      done_o <= 1'b0;
    end else if (start_rise) begin
      done_o <= 1'b0;
    end else if (state_q == st_wait_data && check_done_i) begin
      done_o <= 1'b1;
    end
  end

  // Almost full at a burst boundary holds off the next address write
  a_no_af_we_in_backoff: assert property (@(posedge clk) disable iff (harness_rst_o)
    (state_q inside {st_wr_beat1, st_rd_issue}) && !last_burst_i && afull |=> !af_we_o);

endmodule

//--- pattern_gen.sv
// Burst address and write pattern source; the range start plus size must not wrap the burst address
module pattern_gen import ddr_test_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 31
) (
  input  logic                    clk,
  input  test_state_e             state_i,
  input  logic [ADDR_WIDTH-3:0]   test_start_i,
  input  logic [ADDR_WIDTH-3:0]   test_size_i,
  output logic [ADDR_WIDTH-3:0]   burst_addr_o,
  output logic                    last_burst_o,
  output logic [ADDR_WIDTH-1:0]   ddr_addr_o,
  output logic [2*DATA_WIDTH-1:0] ddr_data_o
);

  localparam int words_per_beat = words_per_burst / beats_per_burst;

  logic [DATA_WIDTH-1:0] pat_cnt;
  logic [ADDR_WIDTH-3:0] last_addr;

  always_ff @(posedge clk) begin
    if (state_i == st_idle || state_i == st_rd_turn) begin
      burst_addr_o <= test_start_i;
    end else if (state_i == st_wr_beat1 || state_i == st_rd_issue) begin
      burst_addr_o <= burst_addr_o + 1'b1; // One step per completed burst
    end
  end

  always_ff @(posedge clk) begin
    if (state_i == st_idle) begin
      pat_cnt <= '0;
    end else if (state_i == st_wr_beat0 || state_i == st_wr_beat1) begin
      pat_cnt <= pat_cnt + DATA_WIDTH'(words_per_beat);
    end
  end

  assign last_addr    = test_start_i + test_size_i - 1'b1;
  assign last_burst_o = (burst_addr_o == last_addr);

  // Byte address, four per burst
  assign ddr_addr_o = {burst_addr_o, 2'b00};
  assign ddr_data_o = {pat_cnt + 1'b1, pat_cnt}; // Odd word high

endmodule

//--- read_aligner.sv
// Pairs read beats into bursts; the controller must deliver both beats of a burst on consecutive cycles
module read_aligner import ddr_test_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  localparam int BURST_W   = words_per_burst * DATA_WIDTH
) (
  input  logic                    clk,
  input  logic                    harness_rst_i,
  input  logic [2*DATA_WIDTH-1:0] ddr_data_i,
  input  logic                    ddr_dvalid_i,
  output logic                    burst_strobe_o,
  output logic [BURST_W-1:0]      burst_o
);

  logic                    beat_idx;
  logic                    pair_q;  // Beat 1 captured
  logic                    pair_d;
  logic [2*DATA_WIDTH-1:0] beat0_q;
  logic [2*DATA_WIDTH-1:0] beat1_q;

  always_ff @(posedge clk) begin
    if (harness_rst_i) begin
      beat_idx       <= 1'b0;
      pair_q         <= 1'b0;
      pair_d         <= 1'b0;
      burst_strobe_o <= 1'b0;
    end else begin
      beat_idx       <= ddr_dvalid_i & ~beat_idx;
      pair_q         <= ddr_dvalid_i & beat_idx;
      pair_d         <= pair_q;
      burst_strobe_o <= pair_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ddr_dvalid_i && !beat_idx) begin
      beat0_q <= ddr_data_i; // Words 1 and 0
    end
    if (ddr_dvalid_i && beat_idx) begin
      beat1_q <= ddr_data_i; // Words 3 and 2
    end
  end

  // Snapshot before a back-to-back beat 0 overwrites the holding register
  always_ff @(posedge clk) begin
    if (pair_q) begin
      burst_o <= {beat1_q, beat0_q};
    end
  end

  a_beat0_has_beat1: assert property (@(posedge clk) disable iff (harness_rst_i)
    ddr_dvalid_i && !beat_idx |=> ddr_dvalid_i);

endmodule

//--- data_checker.sv
// Read-back compare; the fault memory keeps only the first FAULT_DEPTH faulty bursts of a test
module data_checker import ddr_test_pkg::*; #(
  parameter int DATA_WIDTH  = 64,
  parameter int ADDR_WIDTH  = 31,
  parameter int FAULT_DEPTH = 4,
  localparam int CNT_W      = $clog2(FAULT_DEPTH + 1),
  localparam int BURST_W    = words_per_burst * DATA_WIDTH
) (
  input  logic                                   clk,
  input  logic                                   harness_rst_i,
  input  test_state_e                            state_i,
  input  logic                                   burst_strobe_i,
  input  logic [BURST_W-1:0]                     burst_i,
  input  logic [ADDR_WIDTH-3:0]                  test_start_i,
  input  logic [ADDR_WIDTH-3:0]                  test_size_i,
  output logic                                   check_done_o,
  output logic                                   fault_o,
  output logic [CNT_W-1:0]                       fault_cnt_o,
  output logic [FAULT_DEPTH-1:0][BURST_W-1:0]    fault_data_o,
  output logic [FAULT_DEPTH-1:0][ADDR_WIDTH-1:0] fault_addr_o
);

  logic [DATA_WIDTH-1:0] exp_word_q; // First word of the expected burst
  logic [ADDR_WIDTH-3:0] exp_burst_q;
  logic [ADDR_WIDTH-3:0] last_addr;
  logic [BURST_W-1:0]    exp_data;
  logic                  mismatch;
  logic                  mem_full;

  // Regenerated pattern restarts with the read pass
  always_ff @(posedge clk) begin
    if (state_i == st_rd_turn) begin
      exp_word_q  <= '0;
      exp_burst_q <= test_start_i;
    end else if (burst_strobe_i) begin
      exp_word_q  <= exp_word_q + DATA_WIDTH'(words_per_burst);
      exp_burst_q <= exp_burst_q + 1'b1;
    end
  end

  always_comb begin
    for (int k = 0; k < words_per_burst; k++) begin
      exp_data[k*DATA_WIDTH +: DATA_WIDTH] = exp_word_q + DATA_WIDTH'(k);
    end
  end

  assign last_addr = test_start_i + test_size_i - 1'b1;
  assign mismatch  = burst_strobe_i && (burst_i != exp_data);
  assign mem_full  = (fault_cnt_o == CNT_W'(FAULT_DEPTH));

  always_ff @(posedge clk) begin
    if (harness_rst_i || state_i == st_wr_beat0) begin
      fault_o     <= 1'b0;
      fault_cnt_o <= '0;
    end else if (mismatch) begin
      fault_o <= 1'b1; // Sticky until the next test
      if (!mem_full) begin
        fault_cnt_o <= fault_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mismatch && !mem_full) begin
      fault_data_o[fault_cnt_o] <= burst_i;
      fault_addr_o[fault_cnt_o] <= {exp_burst_q, 2'b00}; // Byte address
    end
  end

  always_ff @(posedge clk) begin
    if (harness_rst_i) begin
      check_done_o <= 1'b0;
    end else begin
      check_done_o <= burst_strobe_i && (exp_burst_q == last_addr);
    end
  end

  a_cnt_saturates: assert property (@(posedge clk) disable iff (harness_rst_i)
    fault_cnt_o <= CNT_W'(FAULT_DEPTH));

endmodule

//--- status_regs.sv
// Status window; reads are combinational and addresses past the last fault entry return 0
module status_regs import ddr_test_pkg::*; #(
  parameter int DATA_WIDTH  = 64,
  parameter int ADDR_WIDTH  = 31,
  parameter int FAULT_DEPTH = 4,
  localparam int CNT_W      = $clog2(FAULT_DEPTH + 1),
  localparam int BURST_W    = words_per_burst * DATA_WIDTH
) (
  input  logic                                   clk,
  input  logic                                   harness_rst_i,
  input  test_state_e                            state_i,
  input  logic                                   af_afull_i,
  input  logic                                   df_afull_i,
  input  logic [ADDR_WIDTH-3:0]                  burst_addr_i,
  input  logic                                   done_i,
  input  logic                                   fault_i,
  input  logic [CNT_W-1:0]                       fault_cnt_i,
  input  logic [FAULT_DEPTH-1:0][BURST_W-1:0]    fault_data_i,
  input  logic [FAULT_DEPTH-1:0][ADDR_WIDTH-1:0] fault_addr_i,
  input  logic [status_addr_bits-1:0]            status_addr_i,
  output logic [word_bits-1:0]                   status_data_o
);

  localparam int data_words  = BURST_W / word_bits;
  localparam int entry_words = data_words + 2; // Data then byte address

  logic                  afull_flag;
  logic [ADDR_WIDTH-3:0] afull_addr;

  // First almost-full event only
  always_ff @(posedge clk) begin
    if (harness_rst_i) begin
      afull_flag <= 1'b0;
      afull_addr <= '0;
    end else if ((af_afull_i || df_afull_i) && state_i != st_idle && !afull_flag) begin
      afull_flag <= 1'b1;
      afull_addr <= burst_addr_i;
    end
  end

  always_comb begin
    logic [2*word_bits-1:0]                    afull_ext;
    logic [2*word_bits-1:0]                    addr_ext;
    logic [entry_words*word_bits-1:0]          entry;
    status_data_o = '0;
    afull_ext = '0;
    afull_ext[ADDR_WIDTH-3:0] = afull_addr;
    if (status_addr_i == 0) begin
      status_data_o[flag_done_bit]                = done_i;
      status_data_o[flag_fault_bit]               = fault_i;
      status_data_o[flag_afull_bit]               = afull_flag;
      status_data_o[fault_cnt_lsb +: CNT_W]       = fault_cnt_i;
    end
    if (status_addr_i == afull_addr_word) status_data_o = afull_ext[word_bits-1:0];
    if (status_addr_i == afull_addr_word + 1) status_data_o = afull_ext[2*word_bits-1:word_bits];
    for (int i = 0; i < FAULT_DEPTH; i++) begin
      addr_ext = '0;
      addr_ext[ADDR_WIDTH-1:0] = fault_addr_i[i];
      entry = {addr_ext, fault_data_i[i]};
      for (int j = 0; j < entry_words; j++) begin
        if (status_addr_i == fault_base_word + i*entry_words + j) begin
          status_data_o = entry[j*word_bits +: word_bits]; // Lowest word first
        end
      end
    end
  end

endmodule

//--- ddr_test_harness.sv
// DDR test harness top; test_start_i and test_size_i must hold still during a test, ADDR_WIDTH <= 32
module ddr_test_harness import ddr_test_pkg::*; #(
  parameter int DATA_WIDTH  = 64,
  parameter int ADDR_WIDTH  = 31,
  parameter int FAULT_DEPTH = 4,
  localparam int CNT_W      = $clog2(FAULT_DEPTH + 1),
  localparam int BURST_W    = words_per_burst * DATA_WIDTH
) (
  input  logic                        clk,
  input  logic                        module_rst,
  input  logic                        start_i,
  input  logic                        soft_rst_i,
  input  logic                        phy_rdy_i,
  input  logic [ADDR_WIDTH-3:0]       test_start_i,
  input  logic [ADDR_WIDTH-3:0]       test_size_i,
  output logic                        ddr_rd_wr_n_o,
  output logic [ADDR_WIDTH-1:0]       ddr_addr_o,
  output logic [2*DATA_WIDTH-1:0]     ddr_data_o,
  output logic                        ddr_af_we_o,
  output logic                        ddr_df_we_o,
  input  logic                        ddr_af_afull_i,
  input  logic                        ddr_df_afull_i,
  input  logic [2*DATA_WIDTH-1:0]     ddr_data_i,
  input  logic                        ddr_dvalid_i,
  input  logic [status_addr_bits-1:0] status_addr_i,
  output logic [word_bits-1:0]        status_data_o
);

  logic                                    harness_rst;
  test_state_e                             state;
  logic [ADDR_WIDTH-3:0]                   burst_addr;
  logic                                    last_burst;
  logic                                    burst_strobe;
  logic [BURST_W-1:0]                      burst;
  logic                                    check_done;
  logic                                    done;
  logic                                    fault;
  logic [CNT_W-1:0]                        fault_cnt;
  logic [FAULT_DEPTH-1:0][BURST_W-1:0]     fault_data;
  logic [FAULT_DEPTH-1:0][ADDR_WIDTH-1:0]  fault_addr;

  test_ctrl u_test_ctrl (
    .clk           (clk),
    .module_rst    (module_rst),
    .start_i       (start_i),
    .soft_rst_i    (soft_rst_i),
    .phy_rdy_i     (phy_rdy_i),
    .af_afull_i    (ddr_af_afull_i),
    .df_afull_i    (ddr_df_afull_i),
    .last_burst_i  (last_burst),
    .check_done_i  (check_done),
    .harness_rst_o (harness_rst),
    .state_o       (state),
    .rd_wr_n_o     (ddr_rd_wr_n_o),
    .af_we_o       (ddr_af_we_o),
    .df_we_o       (ddr_df_we_o),
    .done_o        (done)
  );

  pattern_gen #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_pattern_gen (
    .clk          (clk),
    .state_i      (state),
    .test_start_i (test_start_i),
    .test_size_i  (test_size_i),
    .burst_addr_o (burst_addr),
    .last_burst_o (last_burst),
    .ddr_addr_o   (ddr_addr_o),
    .ddr_data_o   (ddr_data_o)
  );

  read_aligner #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_read_aligner (
    .clk            (clk),
    .harness_rst_i  (harness_rst),
    .ddr_data_i     (ddr_data_i),
    .ddr_dvalid_i   (ddr_dvalid_i),
    .burst_strobe_o (burst_strobe),
    .burst_o        (burst)
  );

  data_checker #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FAULT_DEPTH (FAULT_DEPTH)
  ) u_data_checker (
    .clk            (clk),
    .harness_rst_i  (harness_rst),
    .state_i        (state),
    .burst_strobe_i (burst_strobe),
    .burst_i        (burst),
    .test_start_i   (test_start_i),
    .test_size_i    (test_size_i),
    .check_done_o   (check_done),
    .fault_o        (fault),
    .fault_cnt_o    (fault_cnt),
    .fault_data_o   (fault_data),
    .fault_addr_o   (fault_addr)
  );

  status_regs #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FAULT_DEPTH (FAULT_DEPTH)
  ) u_status_regs (
    .clk           (clk),
    .harness_rst_i (harness_rst),
    .state_i       (state),
    .af_afull_i    (ddr_af_afull_i),
    .df_afull_i    (ddr_df_afull_i),
    .burst_addr_i  (burst_addr),
    .done_i        (done),
    .fault_i       (fault),
    .fault_cnt_i   (fault_cnt),
    .fault_data_i  (fault_data),
    .fault_addr_i  (fault_addr),
    .status_addr_i (status_addr_i),
    .status_data_o (status_data_o)
  );

endmodule

//--- ddr_fifo_model.sv
// Controller and memory model; reads return at least 3 cycles after issue, one beat pair at a time
module ddr_fifo_model #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 31
) (
  input  logic                    clk,
  input  logic                    module_rst,
  input  logic                    rd_wr_n_i,
  input  logic [ADDR_WIDTH-1:0]   addr_i,
  input  logic [2*DATA_WIDTH-1:0] data_i,
  input  logic                    af_we_i,
  input  logic                    df_we_i,
  input  logic [31:0]             af_from_i,
  input  logic [31:0]             af_to_i,
  input  logic [31:0]             df_from_i,
  input  logic [31:0]             df_to_i,
  input  logic [63:0]             flip_mask_i,
  output logic                    af_afull_o,
  output logic                    df_afull_o,
  output logic [2*DATA_WIDTH-1:0] data_o,
  output logic                    dvalid_o,
  output logic [31:0]             cycle_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int beat_w = 2 * DATA_WIDTH;

  typedef logic [ADDR_WIDTH-3:0] burst_t;

  logic [beat_w-1:0] mem0[burst_t]; // Beat 0 per burst
  logic [beat_w-1:0] mem1[burst_t];
  burst_t            wr_burst;
  burst_t            out_burst;
  burst_t            rd_q[$];
  logic [31:0]       due_q[$];
  logic              beat1_pend;

  always @(posedge clk) begin
    if (module_rst) begin
      cycle_o    <= '0;
      af_afull_o <= 1'b0;
      df_afull_o <= 1'b0;
      dvalid_o   <= 1'b0;
      data_o     <= '0;
      beat1_pend = 1'b0;
      rd_q.delete();
      due_q.delete();
    end else begin
      cycle_o    <= cycle_o + 1;
      af_afull_o <= (cycle_o >= af_from_i) && (cycle_o < af_to_i);
      df_afull_o <= (cycle_o >= df_from_i) && (cycle_o < df_to_i);
      if (af_we_i && !rd_wr_n_i) wr_burst = addr_i[ADDR_WIDTH-1:2]; // Beat 0 names the burst
      if (df_we_i) begin
        if (af_we_i && !rd_wr_n_i) mem0[wr_burst] = data_i;
        else mem1[wr_burst] = data_i;
      end
      if (af_we_i && rd_wr_n_i) begin
        rd_q.push_back(addr_i[ADDR_WIDTH-1:2]);
        due_q.push_back(cycle_o + 3);
      end
      dvalid_o <= 1'b0;
      if (beat1_pend) begin
        data_o     <= mem1.exists(out_burst) ? mem1[out_burst] : '0;
        dvalid_o   <= 1'b1;
        beat1_pend = 1'b0;
      end else if (due_q.size() > 0 && due_q[0] <= cycle_o) begin
        out_burst = rd_q.pop_front();
        void'(due_q.pop_front());
        // Error knob flips bit 0 of word 0
        data_o     <= (mem0.exists(out_burst) ? mem0[out_burst] : '0)
                      ^ beat_w'(flip_mask_i[out_burst[5:0]]);
        dvalid_o   <= 1'b1;
        beat1_pend = 1'b1;
      end
    end
  end

endmodule

//--- tb_ddr_test_harness.sv
// Directed testbench for default parameters; all tests use bursts 16 to 23, and fault knobs index burst address bits 5:0
module tb_ddr_test_harness import ddr_test_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH  = 64;
  localparam int ADDR_WIDTH  = 31;
  localparam int FAULT_DEPTH = 4;
  localparam int cnt_w       = $clog2(FAULT_DEPTH + 1);
  localparam int entry_words = 18; // 16 data words then 2 address words
  localparam int first_burst = 16;
  localparam int num_bursts  = 8;
  localparam int done_limit  = 400; // Cycles

  logic                        clk;
  logic                        module_rst;
  logic                        start;
  logic                        soft_rst;
  logic                        phy_rdy;
  logic [ADDR_WIDTH-3:0]       test_start;
  logic [ADDR_WIDTH-3:0]       test_size;
  logic                        ddr_rd_wr_n;
  logic [ADDR_WIDTH-1:0]       ddr_addr;
  logic [2*DATA_WIDTH-1:0]     ddr_wdata;
  logic [2*DATA_WIDTH-1:0]     ddr_rdata;
  logic                        ddr_af_we;
  logic                        ddr_df_we;
  logic                        ddr_af_afull;
  logic                        ddr_df_afull;
  logic                        ddr_dvalid;
  logic [status_addr_bits-1:0] status_addr;
  logic [word_bits-1:0]        status_data;
  logic [31:0]                 af_from;
  logic [31:0]                 af_to;
  logic [31:0]                 df_from;
  logic [31:0]                 df_to;
  logic [31:0]                 model_cycle;
  logic [63:0]                 flip_mask;
  logic                        afull_any;

  int                          errors = 0;
  int                          checks = 0;
  int                          blocked_cycles = 0;
  logic                        wr_blocked;
  logic                        rd_blocked;
  logic [ADDR_WIDTH-1:0]       wr_addr_q[$];
  logic [2*DATA_WIDTH-1:0]     wr_data_q[$];

  ddr_test_harness #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FAULT_DEPTH (FAULT_DEPTH)
  ) dut_i (
    .clk            (clk),
    .module_rst     (module_rst),
    .start_i        (start),
    .soft_rst_i     (soft_rst),
    .phy_rdy_i      (phy_rdy),
    .test_start_i   (test_start),
    .test_size_i    (test_size),
    .ddr_rd_wr_n_o  (ddr_rd_wr_n),
    .ddr_addr_o     (ddr_addr),
    .ddr_data_o     (ddr_wdata),
    .ddr_af_we_o    (ddr_af_we),
    .ddr_df_we_o    (ddr_df_we),
    .ddr_af_afull_i (ddr_af_afull),
    .ddr_df_afull_i (ddr_df_afull),
    .ddr_data_i     (ddr_rdata),
    .ddr_dvalid_i   (ddr_dvalid),
    .status_addr_i  (status_addr),
    .status_data_o  (status_data)
  );

  ddr_fifo_model #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_model (
    .clk         (clk),
    .module_rst  (module_rst),
    .rd_wr_n_i   (ddr_rd_wr_n),
    .addr_i      (ddr_addr),
    .data_i      (ddr_wdata),
    .af_we_i     (ddr_af_we),
    .df_we_i     (ddr_df_we),
    .af_from_i   (af_from),
    .af_to_i     (af_to),
    .df_from_i   (df_from),
    .df_to_i     (df_to),
    .flip_mask_i (flip_mask),
    .af_afull_o  (ddr_af_afull),
    .df_afull_o  (ddr_df_afull),
    .data_o      (ddr_rdata),
    .dvalid_o    (ddr_dvalid),
    .cycle_o     (model_cycle)
  );

  assign afull_any = ddr_af_afull | ddr_df_afull;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %0h expected %0h", name, got, exp);
    end
  endtask

  // Write log, and the back-off rule at burst boundaries
  always @(negedge clk) begin
    if (module_rst) begin
      wr_blocked = 1'b0;
      rd_blocked = 1'b0;
    end else begin
      if (ddr_af_we && !ddr_rd_wr_n) wr_addr_q.push_back(ddr_addr);
      if (ddr_df_we) wr_data_q.push_back(ddr_wdata);
      if (wr_blocked || rd_blocked) blocked_cycles++;
      if (wr_blocked) check_eq("ddr_af_we_o write under almost full", ddr_af_we && !ddr_rd_wr_n, 0);
      if (rd_blocked) check_eq("ddr_af_we_o read under almost full", ddr_af_we && ddr_rd_wr_n, 0);
      wr_blocked = (wr_blocked || (ddr_df_we && !ddr_af_we)) && afull_any; // After beat 1
      rd_blocked = (rd_blocked || (ddr_af_we && ddr_rd_wr_n)) && afull_any;
    end
  end

  function automatic logic [255:0] pattern_burst(input int n);
    logic [255:0] b;
    for (int k = 0; k < words_per_burst; k++) begin
      b[k*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(words_per_burst * n + k);
    end
    return b;
  endfunction

  task automatic read_status(input int addr, output logic [word_bits-1:0] data);
    @(negedge clk);
    status_addr = addr[status_addr_bits-1:0];
    #2;
    data = status_data;
  endtask

  task automatic start_test(input int first, input int size);
    @(negedge clk);
    wr_addr_q.delete();
    wr_data_q.delete();
    test_start = first[ADDR_WIDTH-3:0];
    test_size  = size[ADDR_WIDTH-3:0];
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic pulse_soft_reset();
    @(negedge clk);
    soft_rst = 1'b1;
    @(negedge clk);
    soft_rst = 1'b0;
  endtask

  task automatic wait_done(output logic [word_bits-1:0] word0);
    int n;
    n     = 0;
    word0 = '0;
    while (!word0[flag_done_bit] && n < done_limit) begin
      read_status(0, word0);
      n++;
    end
    if (!word0[flag_done_bit]) begin
      errors++;
      $display("Timeout: the test did not finish within %0d cycles", done_limit);
    end
  endtask

  task automatic check_flags(input logic [word_bits-1:0] w, input logic done, input logic fault,
                             input int cnt);
    check_eq("status done flag", w[flag_done_bit], done);
    check_eq("status fault flag", w[flag_fault_bit], fault);
    check_eq("status fault count", w[fault_cnt_lsb +: cnt_w], cnt);
  endtask

  task automatic check_entry(input int idx, input logic [255:0] exp_data, input int byte_addr);
    logic [word_bits-1:0] w;
    logic [255:0]         got_data;
    logic [31:0]          got_addr;
    int                   base;
    base = fault_base_word + idx * entry_words;
    for (int j = 0; j < 16; j++) begin
      read_status(base + j, w);
      got_data[j*word_bits +: word_bits] = w; // Lowest word first
    end
    read_status(base + 16, w);
    got_addr[15:0] = w;
    read_status(base + 17, w);
    got_addr[31:16] = w;
    check_eq($sformatf("fault entry %0d data", idx), got_data, exp_data);
    check_eq($sformatf("fault entry %0d address", idx), got_addr, byte_addr);
  endtask

  task automatic test_reset_state();
    logic [word_bits-1:0] w;
    read_status(0, w);
    check_eq("ddr_af_we_o", ddr_af_we, 0);
    check_eq("ddr_df_we_o", ddr_df_we, 0);
    check_eq("status word 0", w, 0);
  endtask

  task automatic test_clean_run();
    logic [word_bits-1:0] w;
    start_test(first_burst, num_bursts);
    wait_done(w);
    check_flags(w, 1'b1, 1'b0, 0);
    check_eq("write burst count", wr_addr_q.size(), num_bursts);
    foreach (wr_addr_q[i]) check_eq("ddr_addr_o", wr_addr_q[i], (first_burst + i) * 4);
    check_eq("write beat count", wr_data_q.size(), beats_per_burst * num_bursts);
    foreach (wr_data_q[i]) begin
      check_eq("ddr_data_o", wr_data_q[i], {DATA_WIDTH'(2 * i + 1), DATA_WIDTH'(2 * i)});
    end
  endtask

  task automatic test_almost_full();
    logic [word_bits-1:0] w;
    logic [word_bits-1:0] lo;
    logic [word_bits-1:0] hi;
    logic [31:0]          c;
    logic [31:0]          a;
    start_test(first_burst, num_bursts);
    c              = model_cycle;
    blocked_cycles = 0;
    df_from        = c + 4;  // Inside the write pass
    df_to          = c + 9;
    af_from        = c + 26; // Inside the read pass
    af_to          = c + 30;
    wait_done(w);
    df_from = '0;
    df_to   = '0;
    af_from = '0;
    af_to   = '0;
    check_flags(w, 1'b1, 1'b0, 0);
    check_eq("status almost-full flag", w[flag_afull_bit], 1);
    read_status(afull_addr_word, lo);
    read_status(afull_addr_word + 1, hi);
    a = {hi, lo};
    check_eq("almost-full address in range", a >= first_burst && a < first_burst + num_bursts, 1);
    check_eq("back-off cycles seen", blocked_cycles > 0, 1);
    check_eq("write burst count", wr_addr_q.size(), num_bursts);
  endtask

  task automatic test_single_fault();
    logic [word_bits-1:0] w;
    flip_mask = 64'(1) << (first_burst + 5);
    start_test(first_burst, num_bursts);
    wait_done(w);
    flip_mask = '0;
    check_flags(w, 1'b1, 1'b1, 1);
    check_entry(0, pattern_burst(5) ^ 256'(1), (first_burst + 5) * 4);
  endtask

  task automatic test_fault_saturation();
    logic [word_bits-1:0] w;
    int                   bad[6] = '{1, 2, 4, 5, 6, 7};
    flip_mask = '0;
    foreach (bad[i]) flip_mask[first_burst + bad[i]] = 1'b1;
    start_test(first_burst, num_bursts);
    wait_done(w);
    flip_mask = '0;
    check_flags(w, 1'b1, 1'b1, FAULT_DEPTH);
    for (int i = 0; i < FAULT_DEPTH; i++) begin
      check_entry(i, pattern_burst(bad[i]) ^ 256'(1), (first_burst + bad[i]) * 4);
    end
  endtask

  task automatic test_soft_reset();
    logic [word_bits-1:0] w;
    logic [31:0]          c;
    pulse_soft_reset(); // Earlier tests left the sticky almost-full flag set
    read_status(0, w);
    check_eq("status word 0 before soft reset test", w, 0);
    start_test(first_burst, num_bursts);
    c       = model_cycle;
    df_from = c + 2;
    df_to   = c + 5;
    repeat (6) @(negedge clk); // Still in the write pass
    read_status(0, w);
    check_eq("almost-full flag before soft reset", w[flag_afull_bit], 1);
    pulse_soft_reset();
    df_from  = '0;
    df_to    = '0;
    for (int i = 0; i < 10; i++) begin
      read_status(0, w);
      check_eq("status word 0 after soft reset", w, 0);
      check_eq("ddr_af_we_o after soft reset", ddr_af_we, 0);
      check_eq("ddr_df_we_o after soft reset", ddr_df_we, 0);
    end
    start_test(first_burst, num_bursts);
    wait_done(w);
    check_eq("status word 0 after restart", w, 1 << flag_done_bit);
    check_eq("write burst count", wr_addr_q.size(), num_bursts);
  endtask

  initial begin
    module_rst  = 1'b1;
    start       = 1'b0;
    soft_rst    = 1'b0;
    phy_rdy     = 1'b1;
    test_start  = '0;
    test_size   = 1;
    status_addr = '0;
    af_from     = '0;
    af_to       = '0;
    df_from     = '0;
    df_to       = '0;
    flip_mask   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    module_rst = 1'b0;

    test_reset_state();
    test_clean_run();
    test_almost_full();
    test_single_fault();
    test_fault_saturation();
    test_soft_reset();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
ddr_test_pkg.sv
test_ctrl.sv
pattern_gen.sv
read_aligner.sv
data_checker.sv
status_regs.sv
ddr_test_harness.sv
ddr_fifo_model.sv
tb_ddr_test_harness.sv

//--- Bender.yml
package:
  name: ddr_test_harness

sources:
  - ddr_test_pkg.sv
  - test_ctrl.sv
  - pattern_gen.sv
  - read_aligner.sv
  - data_checker.sv
  - status_regs.sv
  - ddr_test_harness.sv
  - target: test
    files:
      - ddr_fifo_model.sv
      - tb_ddr_test_harness.sv
